// File: verification/sfi_rx_cases.txt
# kind conn par_off map hv hvc hfc hpar dv dstart dend poison edb perr_inj aux_inj ivc ifc
#   then expected: hv hvc hpar dv dvc dfc err_set edb poison perr par_inv (idle: conn dly early blk ack)
0 1 0 01233210 1 5 2 1 1 1 0 0 0 0 0 6 1  1 2 0 1 1 1 0 0 0 0 0
0 1 0 01233210 0 0 0 0 1 0 0 0 0 0 0 3 3  0 0 0 1 1 1 0 0 0 0 0
0 1 0 01233210 0 0 0 0 1 0 8 0 0 0 0 0 0  0 0 0 1 1 1 0 0 0 0 0
0 1 0 01233210 1 B 1 0 0 0 0 0 0 0 0 0 0  1 3 1 0 1 1 0 0 0 0 0
0 1 0 FFFFFFFF 1 2 0 0 1 1 1 0 0 0 0 4 2  1 3 1 1 3 2 0 0 0 0 0
0 1 0 01233210 0 0 0 0 1 1 2 6 9 0 0 1 0  0 0 0 1 1 0 6 1 2 0 1
0 1 0 01233210 0 0 0 0 1 0 1 C 2 0 0 0 0  0 0 0 1 1 0 0 0 0 0 0
0 1 0 01233210 0 0 0 0 1 1 8 0 0 2 0 7 3  0 0 0 1 0 3 1 0 0 2 2
0 1 0 01233210 0 0 0 0 1 0 8 8 0 3 0 0 0  0 0 0 1 0 3 3 0 8 3 3
0 1 1 01233210 0 0 0 0 1 1 8 0 0 3 0 0 0  0 0 0 1 0 0 0 0 0 0 0
0 0 0 01233210 1 6 1 0 1 1 8 0 0 0 0 0 0  0 1 1 0 0 0 0 0 0 0 0
1 1 0 0 9 13
1 1 1 1 17 21
1 1 2 0 33 37
1 0 0 0 0 0
0 1 1 01233210 1 1 3 1 1 1 1 0 0 0 1 3 1  1 1 1 1 3 1 0 0 0 0 1
0 1 0 01233210 1 4 0 0 1 1 1 0 0 0 0 4 2  1 3 1 1 3 2 0 0 0 0 0
0 1 0 01233210 1 0 0 0 1 1 1 0 0 0 1 2 1  0 0 0 1 2 1 8 0 0 0 0
0 1 0 01233210 1 3 2 0 1 1 1 0 0 0 0 5 2  0 3 0 0 2 2 0 0 0 0 0

// File: flist.f
+incdir+src
src/sfi_rx_pkg.sv
src/sfi_rx_hdr_path.sv
src/sfi_rx_data_path.sv
src/sfi_rx_data_check.sv
src/sfi_rx_idle_ctl.sv
src/sfi_rx_top.sv
verification/sfi_rx_checker.sv
verification/tb_sfi_rx.sv

// File: verification/tb_sfi_rx.sv
// Testbench top for the fabric receive link, reads cases from the case file and drives the DUT
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module tb_sfi_rx
  import sfi_rx_pkg::*;
;

  logic                    clk;
  logic                    rst_b;
  logic                    tx_connected;
  logic [2:0]              cfg_idle_dly;
  logic [`SFI_RXMAP_W-1:0] cfg_vc_rxmap;
  logic                    cfg_par_off;
  logic                    go_idle;
  logic                    hdr_early_valid;
  logic                    data_early_valid;
  sfi_rx_hdr_t             rx_hdr;
  sfi_rx_data_t            rx_data;

  logic                    hdr_block;
  logic                    go_idle_ack;
  logic                    agent_hdr_v;
  logic [`SFI_VC_W-1:0]    agent_hdr_vc;
  sfi_fc_t                 agent_hdr_fc;
  logic [3:0]              agent_hdr_size;
  logic                    agent_hdr_has_data;
  logic [`SFI_HDR_W-1:0]   agent_hdr;
  logic                    agent_hdr_par;
  logic                    agent_data_v;
  logic [`SFI_VC_W-1:0]    agent_data_vc;
  sfi_fc_t                 agent_data_fc;
  logic [`SFI_DATA_W-1:0]  agent_data;
  logic [`SFI_PAR_CNT-1:0] agent_data_par;
  logic [3:0]              err_set;
  logic [`SFI_HDR_W-1:0]   aux_hdr;
  logic [`SFI_DW_CNT-1:0]  edb_synd;
  logic [`SFI_DW_CNT-1:0]  poison_synd;
  logic [`SFI_PAR_CNT-1:0] perr_synd;

  // Expected values handed to the checker and the enables for each kind of check
  logic                    chk_beat;
  logic                    chk_idle;
  logic                    exp_hdr_v;
  logic [`SFI_VC_W-1:0]    exp_hdr_vc;
  logic                    exp_hdr_par;
  logic                    exp_data_v;
  logic [`SFI_VC_W-1:0]    exp_data_vc;
  logic [1:0]              exp_data_fc;
  logic [`SFI_PAR_CNT-1:0] exp_data_par;
  logic [3:0]              exp_err_set;
  logic [`SFI_DW_CNT-1:0]  exp_edb;
  logic [`SFI_DW_CNT-1:0]  exp_poison;
  logic [`SFI_PAR_CNT-1:0] exp_perr;
  logic [`SFI_HDR_W-1:0]   exp_aux_hdr;
  logic                    exp_block;
  logic                    exp_ack;
  int                      err_cnt;

  // Random payload state and case bookkeeping
  logic [31:0]             lfsr;
  logic [`SFI_HDR_W-1:0]   last_push;
  logic [31:0]             f [0:27];
  string                   lines [$];
  int                      n_cases;

  // 4 ns clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  sfi_rx_top UUT (.*);

  sfi_rx_checker u_checker (.*, .rx_data_payload(rx_data.data));

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  // ----------------------------------------------------------------------
  // One cycle with a header beat and a data beat
  // ----------------------------------------------------------------------

  task automatic run_beat();
    logic [127:0] bits;
    logic [1:0]   spar;
    tx_connected = f[1][0];
    cfg_par_off  = f[2][0];
    cfg_vc_rxmap = f[3];
    rand_bits(64, bits);
    rx_hdr.header = bits[63:0];
    rand_bits(5, bits);
    rx_hdr.info.hdr_size = bits[3:0];
    rx_hdr.info.has_data = bits[4];
    rx_hdr.hdr_valid     = f[4][0];
    rx_hdr.info.vc_id    = f[5][3:0];
    rx_hdr.info.fc_id    = f[6][1:0];
    rx_hdr.info.parity   = f[7][0];
    rand_bits(128, bits);
    rx_data.data        = bits;
    rx_data.data_valid  = f[8][0];
    rx_data.data_start  = f[9][0];
    rx_data.data_end    = f[10][3:0];
    rx_data.data_poison = f[11][3:0];
    rx_data.data_edb    = f[12][3:0];
    rx_data.info.vc_id  = f[15][3:0];
    rx_data.info.fc_id  = f[16][1:0];
    rx_data.info.rsvd   = 2'b00;
    // Slice parity with the injected errors flipped in
    for (int i = 0; i < 2; i++) begin
      spar[i] = ^bits[i*64 +: 64];
    end
    rx_data.data_parity = spar ^ f[13][1:0];
    rx_data.data_aux_parity = f[14][0] ^ (^{rx_data.data_poison, rx_data.data_edb,
                                            rx_data.data_start, rx_data.data_end,
                                            rx_data.info});
    exp_hdr_v    = f[17][0];
    exp_hdr_vc   = f[18][1:0];
    exp_hdr_par  = f[19][0];
    exp_data_v   = f[20][0];
    exp_data_vc  = f[21][1:0];
    exp_data_fc  = f[22][1:0];
    exp_err_set  = f[23][3:0];
    exp_edb      = f[24][3:0];
    exp_poison   = f[25][3:0];
    exp_perr     = f[26][1:0];
    exp_data_par = spar ^ f[27][1:0];
    exp_aux_hdr  = last_push;
    chk_beat = 1'b1;
    @(negedge clk);
    chk_beat = 1'b0;
    if (f[17][0]) begin
      last_push = rx_hdr.header;
    end
    rx_hdr.hdr_valid   = 1'b0;
    rx_data.data_valid = 1'b0;
    tx_connected       = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Idle handshake with cycle counts from the case line
  // ----------------------------------------------------------------------

  task automatic run_idle();
    int limit;
    // Clear any block left by the previous request
    tx_connected = 1'b1;
    go_idle      = 1'b0;
    @(negedge clk);
    tx_connected = f[1][0];
    cfg_idle_dly = f[2][2:0];
    go_idle      = 1'b1;
    limit = (f[4] == 0) ? 40 : int'(f[5]) + 2;
    chk_idle = 1'b1;
    for (int k = 0; k <= limit; k++) begin
      exp_block = (f[4] != 0) && (k >= f[4]);
      exp_ack   = (f[5] != 0) && (k >= f[5]);
      @(negedge clk);
    end
    if (f[3][0]) begin
      // Ack drops at once and the block follows at the next edge
      hdr_early_valid = 1'b1;
      exp_block       = 1'b1;
      exp_ack         = 1'b0;
      @(negedge clk);
      hdr_early_valid = 1'b0;
      exp_block       = 1'b0;
      @(negedge clk);
    end
    chk_idle     = 1'b0;
    go_idle      = 1'b0;
    tx_connected = 1'b1;
  endtask

  // Watchdog allows 200 cycles per case
  initial begin
    wait (n_cases > 0);
    #(n_cases * 200 * 4);
    $display("Timeout: the run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int    fd;
    int    rc;
    int    prev;
    string s;
    rst_b = 1'b0;
    tx_connected = 1'b1;
    cfg_idle_dly = 3'd0;
    cfg_vc_rxmap = 32'h0123_3210;
    cfg_par_off = 1'b0;
    go_idle = 1'b0;
    hdr_early_valid = 1'b0;
    data_early_valid = 1'b0;
    rx_hdr = '0;
    rx_data = '0;
    chk_beat = 1'b0;
    chk_idle = 1'b0;
    exp_block = 1'b0;
    exp_ack = 1'b0;
    lfsr = 32'hff8f_d4bb;
    last_push = '0;
    n_cases = 0;
    fd = $fopen("verification/sfi_rx_cases.txt", "r");
    if (fd == 0) begin
      $display("Case file could not be opened");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        s = "";
        rc = $fgets(s, fd);
        if (s.len() > 1 && s.getc(0) != "#") begin
          lines.push_back(s);
        end
      end
      $fclose(fd);
      n_cases = lines.size();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_b = 1'b1;
      // Outputs must be quiet straight after reset
      chk_idle = 1'b1;
      @(negedge clk);
      chk_idle = 0;
      for (int c = 0; c < n_cases; c++) begin
        prev = err_cnt;
        rc = $sscanf(lines[c], "%h", f[0]);
        if (f[0] == 0) begin
          rc = $sscanf(lines[c],
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
            f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
            f[24], f[25], f[26], f[27]);
          run_beat();
        end else begin
          // Idle lines carry decimal cycle counts
          rc = $sscanf(lines[c], "%d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5]);
          run_idle();
        end
        $display("Case %0d %s: %0d errors", c + 1, (f[0] == 0) ? "beat" : "idle",
                 err_cnt - prev);
      end
      $display("Cases run %0d, errors %0d", n_cases, err_cnt);
      if (err_cnt == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: verification/sfi_rx_checker.sv
// Checker that samples the DUT outputs late in each cycle and compares them with expected values
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_checker (
  input  logic                    clk,
  input  logic                    chk_beat,
  input  logic                    chk_idle,
  input  logic                    hdr_block,
  input  logic                    go_idle_ack,
  input  logic                    agent_hdr_v,
  input  logic [`SFI_VC_W-1:0]    agent_hdr_vc,
  input  logic [1:0]              agent_hdr_fc,
  input  logic [3:0]              agent_hdr_size,
  input  logic                    agent_hdr_has_data,
  input  logic [`SFI_HDR_W-1:0]   agent_hdr,
  input  logic                    agent_hdr_par,
  input  logic                    agent_data_v,
  input  logic [`SFI_VC_W-1:0]    agent_data_vc,
  input  logic [1:0]              agent_data_fc,
  input  logic [`SFI_DATA_W-1:0]  agent_data,
  input  logic [`SFI_PAR_CNT-1:0] agent_data_par,
  input  logic [3:0]              err_set,
  input  logic [`SFI_HDR_W-1:0]   aux_hdr,
  input  logic [`SFI_DW_CNT-1:0]  edb_synd,
  input  logic [`SFI_DW_CNT-1:0]  poison_synd,
  input  logic [`SFI_PAR_CNT-1:0] perr_synd,
  // Beats as driven, for the pass-through fields
  input  logic [`SFI_HDR_W+12:0]  rx_hdr,
  input  logic [`SFI_DATA_W-1:0]  rx_data_payload,
  input  logic                    exp_hdr_v,
  input  logic [`SFI_VC_W-1:0]    exp_hdr_vc,
  input  logic                    exp_hdr_par,
  input  logic                    exp_data_v,
  input  logic [`SFI_VC_W-1:0]    exp_data_vc,
  input  logic [1:0]              exp_data_fc,
  input  logic [`SFI_PAR_CNT-1:0] exp_data_par,
  input  logic [3:0]              exp_err_set,
  input  logic [`SFI_DW_CNT-1:0]  exp_edb,
  input  logic [`SFI_DW_CNT-1:0]  exp_poison,
  input  logic [`SFI_PAR_CNT-1:0] exp_perr,
  input  logic [`SFI_HDR_W-1:0]   exp_aux_hdr,
  input  logic                    exp_block,
  input  logic                    exp_ack,
  output int                      err_cnt
);

  initial err_cnt = 0;

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Sample 1 ns before the rising edge, inputs were driven on the falling edge
  always begin
    @(negedge clk);
    #1;
    if (chk_beat) begin
      check_val("agent_hdr_v", agent_hdr_v, exp_hdr_v);
      check_val("agent_hdr_vc", agent_hdr_vc, exp_hdr_vc);
      check_val("agent_hdr_fc", agent_hdr_fc, rx_hdr[`SFI_HDR_W+7 -: 2]);
      check_val("agent_hdr_size", agent_hdr_size, rx_hdr[`SFI_HDR_W+5 -: 4]);
      check_val("agent_hdr_has_data", agent_hdr_has_data, rx_hdr[`SFI_HDR_W+1]);
      check_val("agent_hdr", agent_hdr, rx_hdr[`SFI_HDR_W-1:0]);
      check_val("agent_hdr_par", agent_hdr_par, exp_hdr_par);
      check_val("agent_data_v", agent_data_v, exp_data_v);
      check_val("agent_data_vc", agent_data_vc, exp_data_vc);
      check_val("agent_data_fc", agent_data_fc, exp_data_fc);
      check_val("agent_data", agent_data, rx_data_payload);
      check_val("agent_data_par", agent_data_par, exp_data_par);
      check_val("err_set", err_set, exp_err_set);
      check_val("edb_synd", edb_synd, exp_edb);
      check_val("poison_synd", poison_synd, exp_poison);
      check_val("perr_synd", perr_synd, exp_perr);
      // Logged header only matters with an aux error
      if (exp_err_set[3]) begin
        check_val("aux_hdr", aux_hdr, exp_aux_hdr);
      end
    end
    if (chk_idle) begin
      check_val("hdr_block", hdr_block, exp_block);
      check_val("go_idle_ack", go_idle_ack, exp_ack);
      // No beats in flight during idle cycles
      check_val("agent_hdr_v", agent_hdr_v, 1'b0);
      check_val("agent_data_v", agent_data_v, 1'b0);
      check_val("err_set", err_set, 4'h0);
    end
  end

endmodule

// File: src/sfi_rx_top.sv
// Receive side of the fabric link, instantiate this to connect fabric beats to the agent
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_top
  import sfi_rx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    tx_connected,
  input  logic [2:0]              cfg_idle_dly,
  input  logic [`SFI_RXMAP_W-1:0] cfg_vc_rxmap,
  input  logic                    cfg_par_off,
  input  logic                    go_idle,
  input  logic                    hdr_early_valid,
  input  logic                    data_early_valid,
  input  sfi_rx_hdr_t             rx_hdr,
  input  sfi_rx_data_t            rx_data,
  output logic                    hdr_block,
  output logic                    go_idle_ack,
  output logic                    agent_hdr_v,
  output logic [`SFI_VC_W-1:0]    agent_hdr_vc,
  output sfi_fc_t                 agent_hdr_fc,
  output logic [3:0]              agent_hdr_size,
  output logic                    agent_hdr_has_data,
  output logic [`SFI_HDR_W-1:0]   agent_hdr,
  output logic                    agent_hdr_par,
  output logic                    agent_data_v,
  output logic [`SFI_VC_W-1:0]    agent_data_vc,
  output sfi_fc_t                 agent_data_fc,
  output logic [`SFI_DATA_W-1:0]  agent_data,
  output logic [`SFI_PAR_CNT-1:0] agent_data_par,
  output logic [3:0]              err_set,
  output logic [`SFI_HDR_W-1:0]   aux_hdr,
  output logic [`SFI_DW_CNT-1:0]  edb_synd,
  output logic [`SFI_DW_CNT-1:0]  poison_synd,
  output logic [`SFI_PAR_CNT-1:0] perr_synd
);

  // Aux error of the current beat and the sticky halt built from it
  logic                  aux_perr;
  logic                  halted;
  // Last header pushed, logged with an aux error
  logic [`SFI_HDR_W-1:0] last_hdr;

  sfi_rx_hdr_path u_hdr_path (
    .clk                (clk),
    .rst_b              (rst_b),
    .tx_connected       (tx_connected),
    .cfg_vc_rxmap       (cfg_vc_rxmap),
    .rx_hdr             (rx_hdr),
    .aux_perr           (aux_perr),
    .halted             (halted),
    .agent_hdr_v        (agent_hdr_v),
    .agent_hdr_vc       (agent_hdr_vc),
    .agent_hdr_fc       (agent_hdr_fc),
    .agent_hdr_size     (agent_hdr_size),
    .agent_hdr_has_data (agent_hdr_has_data),
    .agent_hdr          (agent_hdr),
    .agent_hdr_par      (agent_hdr_par),
    .last_hdr           (last_hdr)
  );

  sfi_rx_data_path u_data_path (
    .clk           (clk),
    .rst_b         (rst_b),
    .tx_connected  (tx_connected),
    .cfg_vc_rxmap  (cfg_vc_rxmap),
    .rx_data       (rx_data),
    .halted        (halted),
    .agent_data_v  (agent_data_v),
    .agent_data_vc (agent_data_vc),
    .agent_data_fc (agent_data_fc),
    .agent_data    (agent_data)
  );

  sfi_rx_data_check u_data_check (
    .clk            (clk),
    .rst_b          (rst_b),
    .cfg_par_off    (cfg_par_off),
    .rx_data        (rx_data),
    .last_hdr       (last_hdr),
    .aux_perr       (aux_perr),
    .halted         (halted),
    .agent_data_par (agent_data_par),
    .err_set        (err_set),
    .aux_hdr        (aux_hdr),
    .edb_synd       (edb_synd),
    .poison_synd    (poison_synd),
    .perr_synd      (perr_synd)
  );

  sfi_rx_idle_ctl u_idle_ctl (
    .clk              (clk),
    .rst_b            (rst_b),
    .tx_connected     (tx_connected),
    .cfg_idle_dly     (cfg_idle_dly),
    .go_idle          (go_idle),
    .hdr_early_valid  (hdr_early_valid),
    .data_early_valid (data_early_valid),
    .hdr_block        (hdr_block),
    .go_idle_ack      (go_idle_ack)
  );

endmodule

// File: src/sfi_rx_idle_ctl.sv
// Idle handshake that delays, raises the header block, waits out the fabric stall and acks
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_idle_ctl (
  input  logic       clk,
  input  logic       rst_b,
  input  logic       tx_connected,
  input  logic [2:0] cfg_idle_dly,
  input  logic       go_idle,
  input  logic       hdr_early_valid,
  input  logic       data_early_valid,
  output logic       hdr_block,
  output logic       go_idle_ack
);

  localparam int unsigned STALL_W = $clog2(`SFI_STALL_CNT) + 1;

  logic [`SFI_IDLE_CNT_W-1:0] idle_cnt;
  logic [`SFI_IDLE_CNT_W-1:0] idle_cnt_d;
  logic [STALL_W-1:0]         stall_cnt;
  logic [STALL_W-1:0]         stall_cnt_d;
  logic                       block_d;
  logic                       unblock;
  logic                       idle_hit;
  logic                       stall_done;

  // Drop out of the idle sequence when traffic comes or the request is withdrawn
  assign unblock = tx_connected & (hdr_early_valid | data_early_valid | ~go_idle);

  // Delay done once the counter reaches 2**(cfg_idle_dly+3)
  assign idle_hit   = idle_cnt[{1'b0, cfg_idle_dly} + 4'd3];
  assign stall_done = (stall_cnt == STALL_W'(`SFI_STALL_CNT));

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------

  always_comb begin
    block_d     = hdr_block;
    idle_cnt_d  = idle_cnt;
    stall_cnt_d = stall_cnt;
    // Disconnected link freezes everything
    if (tx_connected) begin
      if (unblock) begin
        block_d     = 1'b0;
        idle_cnt_d  = '0;
        stall_cnt_d = '0;
      end else begin
        // Counter parks at the hit value while the block is up
        if (idle_hit) begin
          block_d = 1'b1;
        end else begin
          idle_cnt_d = idle_cnt + 1'b1;
        end
        // Count fabric stall cycles after the block is seen
        if (!hdr_block) begin
          stall_cnt_d = '0;
        end else if (!stall_done) begin
          stall_cnt_d = stall_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      hdr_block <= 1'b0;
      idle_cnt  <= '0;
      stall_cnt <= '0;
    end else begin
      hdr_block <= block_d;
      idle_cnt  <= idle_cnt_d;
      stall_cnt <= stall_cnt_d;
    end
  end

  // Ack drops in the same cycle the request goes away
  assign go_idle_ack = tx_connected & hdr_block & stall_done & ~unblock;

  // ----------------------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------------------

  // Ack only after the block has been up for the whole fabric stall
  a_ack_after_stall: assert property (
    @(posedge clk) disable iff (!rst_b)
      $rose(go_idle_ack) |-> $past(hdr_block, `SFI_STALL_CNT)
  );

  a_block_needs_req: assert property (
    @(posedge clk) disable iff (!rst_b) $rose(hdr_block) |-> $past(go_idle)
  );

endmodule

// File: src/sfi_rx_data_check.sv
// Data beat checker for parity, poison, EDB and aux errors, with parity folding and sticky halt
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_data_check
  import sfi_rx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    cfg_par_off,
  input  sfi_rx_data_t            rx_data,
  input  logic [`SFI_HDR_W-1:0]   last_hdr,
  output logic                    aux_perr,
  output logic                    halted,
  output logic [`SFI_PAR_CNT-1:0] agent_data_par,
  output logic [3:0]              err_set,
  output logic [`SFI_HDR_W-1:0]   aux_hdr,
  output logic [`SFI_DW_CNT-1:0]  edb_synd,
  output logic [`SFI_DW_CNT-1:0]  poison_synd,
  output logic [`SFI_PAR_CNT-1:0] perr_synd
);

  logic [`SFI_DW_CNT-1:0]  end_mask;
  logic [`SFI_PAR_CNT-1:0] calc_par;
  logic [`SFI_PAR_CNT-1:0] aux_fold;
  logic                    aux_raw;

  // ----------------------------------------------------------------------
  // End mask and word syndromes
  // ----------------------------------------------------------------------

  // Highest end bit wins and covers every word below it
  always_comb begin
    end_mask = '0;
    for (int i = 0; i < `SFI_DW_CNT; i++) begin
      if (rx_data.data_end[i]) begin
        end_mask = {`SFI_DW_CNT{1'b1}} >> (`SFI_DW_CNT - 1 - i);
      end
    end
  end

  // Words past the end of the packet are don't care
  assign edb_synd    = end_mask & rx_data.data_edb;
  assign poison_synd = end_mask & rx_data.data_poison;

  // ----------------------------------------------------------------------
  // Data parity and aux parity
  // ----------------------------------------------------------------------

  assign calc_par  = sfi_word_parity(rx_data.data);
  assign perr_synd = (calc_par ^ rx_data.data_parity) & {`SFI_PAR_CNT{~cfg_par_off}};

  // Aux bit covers the side-band fields of a valid beat
  assign aux_raw = rx_data.data_valid & (^{rx_data.data_aux_parity, rx_data.data_poison,
                                           rx_data.data_edb, rx_data.data_start,
                                           rx_data.data_end, rx_data.info});

  // Parity checks off means an aux error only shows up as bad parity on slice 0
  assign aux_perr = aux_raw & ~cfg_par_off;
  assign aux_fold = {{(`SFI_PAR_CNT-1){1'b0}}, aux_raw & cfg_par_off};

  // Any error in a slice is passed on as inverted parity for that slice
  always_comb begin
    for (int i = 0; i < `SFI_PAR_CNT; i++) begin
      if (|{edb_synd[i*2 +: 2], poison_synd[i*2 +: 2], perr_synd[i], aux_fold[i]}) begin
        agent_data_par[i] = ~calc_par[i];
      end else begin
        agent_data_par[i] = calc_par[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Error report
  // ----------------------------------------------------------------------

  // Order is aux, edb, poison, parity
  assign err_set = {aux_perr, |edb_synd, |poison_synd, |perr_synd};
  assign aux_hdr = last_hdr;

  // Sticky halt that only reset clears
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      halted <= 1'b0;
    end else begin
      halted <= halted | aux_perr;
    end
  end

  // A data end gives a run of low ones that just covers its highest set bit
  a_end_mask_shape: assert property (
    @(posedge clk) disable iff (!rst_b)
      (|rx_data.data_end) |-> (((end_mask & (end_mask + 1'b1)) == '0) &&
                               (end_mask >= rx_data.data_end) &&
                               ((end_mask >> 1) < rx_data.data_end))
  );

endmodule

// File: src/sfi_rx_data_path.sv
// Data path that forwards beats with the packet VC and flow class held and gates the agent push
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_data_path
  import sfi_rx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    tx_connected,
  input  logic [`SFI_RXMAP_W-1:0] cfg_vc_rxmap,
  input  sfi_rx_data_t            rx_data,
  input  logic                    halted,
  output logic                    agent_data_v,
  output logic [`SFI_VC_W-1:0]    agent_data_vc,
  output sfi_fc_t                 agent_data_fc,
  output logic [`SFI_DATA_W-1:0]  agent_data
);

  logic [`SFI_VC_W-1:0] vc_mapped;
  logic [`SFI_VC_W-1:0] saved_vc;
  sfi_fc_t              saved_fc;
  logic                 start_beat;

  // Info byte is valid on the start beat only
  assign start_beat = rx_data.data_valid & rx_data.data_start;
  assign vc_mapped  = sfi_map_vc(cfg_vc_rxmap, rx_data.info.vc_id[2:0]);

  // Start beat uses its own info, later beats reuse what the start beat carried
  assign agent_data_vc = start_beat ? vc_mapped : saved_vc;
  assign agent_data_fc = start_beat ? rx_data.info.fc_id : saved_fc;
  assign agent_data    = rx_data.data;

  // Bad data beat itself still goes out, the halt only stops later beats
  assign agent_data_v = tx_connected & rx_data.data_valid & ~halted;

  // ----------------------------------------------------------------------
  // Packet VC and flow class hold
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      saved_vc <= '0;
      saved_fc <= '0;
    end else if (tx_connected && start_beat) begin
      saved_vc <= vc_mapped;
      saved_fc <= rx_data.info.fc_id;
    end
  end

endmodule

// File: src/sfi_rx_hdr_path.sv
// Header path that remaps the VC, fixes parity, gates the agent push and keeps the last header
`timescale 1ns/1ns
`include "sfi_rx_macros.svh"

module sfi_rx_hdr_path
  import sfi_rx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    tx_connected,
  input  logic [`SFI_RXMAP_W-1:0] cfg_vc_rxmap,
  input  sfi_rx_hdr_t             rx_hdr,
  input  logic                    aux_perr,
  input  logic                    halted,
  output logic                    agent_hdr_v,
  output logic [`SFI_VC_W-1:0]    agent_hdr_vc,
  output sfi_fc_t                 agent_hdr_fc,
  output logic [3:0]              agent_hdr_size,
  output logic                    agent_hdr_has_data,
  output logic [`SFI_HDR_W-1:0]   agent_hdr,
  output logic                    agent_hdr_par,
  output logic [`SFI_HDR_W-1:0]   last_hdr
);

  logic [`SFI_VC_W-1:0] vc_mapped;

  // Internal VC from the low three bits of the external one
  assign vc_mapped = sfi_map_vc(cfg_vc_rxmap, rx_hdr.info.vc_id[2:0]);

  // Header fields pass straight through
  assign agent_hdr_vc       = vc_mapped;
  assign agent_hdr_fc       = rx_hdr.info.fc_id;
  assign agent_hdr_size     = rx_hdr.info.hdr_size;
  assign agent_hdr_has_data = rx_hdr.info.has_data;
  assign agent_hdr          = rx_hdr.header;

  // Swap the external VC out of the parity and the internal VC in
  assign agent_hdr_par = ^{rx_hdr.info.parity, rx_hdr.info.vc_id, vc_mapped};

  // Drop the header alongside a bad data beat, and everything once halted
  assign agent_hdr_v = tx_connected & rx_hdr.hdr_valid & ~(aux_perr | halted);

  // ----------------------------------------------------------------------
  // Last pushed header for the aux parity error report
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      last_hdr <= '0;
    end else if (agent_hdr_v) begin
      last_hdr <= rx_hdr.header;
    end
  end

  // Halt only follows an aux error that already dropped its header
  a_halt_after_aux: assert property (
    @(posedge clk) disable iff (!rst_b) $rose(halted) |-> $past(aux_perr)
  );

endmodule

// File: src/sfi_rx_pkg.sv
// Fabric beat types and VC map and data parity helpers shared by the receive link RTL
`include "sfi_rx_macros.svh"

package sfi_rx_pkg;

  // Flow class
  typedef logic [1:0] sfi_fc_t;

  // ----------------------------------------------------------------------
  // Header beat, wire format from the fabric
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [3:0] vc_id;     // External VC number
    sfi_fc_t    fc_id;
    logic [3:0] hdr_size;
    logic       has_data;
    logic       parity;    // Covers the header and its info bits
  } sfi_hdr_info_t;

  typedef struct packed {
    logic                  hdr_valid;
    sfi_hdr_info_t         info;
    logic [`SFI_HDR_W-1:0] header;
  } sfi_rx_hdr_t;

  // ----------------------------------------------------------------------
  // Data beat, wire format from the fabric
  // ----------------------------------------------------------------------

  // Info byte, only meaningful on the start beat of a packet
  typedef struct packed {
    logic [3:0] vc_id;
    sfi_fc_t    fc_id;
    logic [1:0] rsvd;
  } sfi_data_info_t;

  typedef struct packed {
    logic                    data_valid;
    logic                    data_start;
    logic [`SFI_DW_CNT-1:0]  data_end;
    logic [`SFI_DATA_W-1:0]  data;
    logic [`SFI_PAR_CNT-1:0] data_parity;
    logic [`SFI_DW_CNT-1:0]  data_poison;
    logic [`SFI_DW_CNT-1:0]  data_edb;
    logic                    data_aux_parity;
    sfi_data_info_t          info;
  } sfi_rx_data_t;

  // External VCs 0 to 7 only, slot vc of the table sits at bit vc*4
  function automatic logic [`SFI_VC_W-1:0] sfi_map_vc(input logic [`SFI_RXMAP_W-1:0] map,
                                                      input logic [2:0] vc);
    return map[{vc, 2'b00} +: `SFI_VC_W];
  endfunction

  // XOR parity of each 64-bit slice
  function automatic logic [`SFI_PAR_CNT-1:0] sfi_word_parity(input logic [`SFI_DATA_W-1:0] d);
    logic [`SFI_PAR_CNT-1:0] par;
    for (int i = 0; i < `SFI_PAR_CNT; i++) begin
      par[i] = ^d[i*64 +: 64];
    end
    return par;
  endfunction

endpackage

// File: src/sfi_rx_macros.svh
// Widths, counts and stall depths for the fabric receive link, included by the package and RTL
`ifndef SFI_RX_MACROS_SVH
`define SFI_RX_MACROS_SVH

// ----------------------------------------------------------------------
// Beat widths
// ----------------------------------------------------------------------

// Header flit and data beat payloads
`define SFI_HDR_W      64
`define SFI_DATA_W     128

// One bit per 32-bit word, used by data end, poison and EDB
`define SFI_DW_CNT     4

// One parity bit per 64-bit slice
`define SFI_PAR_CNT    2

// ----------------------------------------------------------------------
// VC mapping
// ----------------------------------------------------------------------

// Internal VC width and the map table of eight 4-bit slots
`define SFI_VC_W       2
`define SFI_RXMAP_W    32

// ----------------------------------------------------------------------
// Idle handshake
// ----------------------------------------------------------------------

// Fabric stall depths on the receive and transmit sides
`define SFI_RBN        3
`define SFI_TX_TBN     2

// Larger stall depth plus one
`define SFI_STALL_CNT  ((`SFI_RBN > `SFI_TX_TBN) ? (`SFI_RBN + 1) : (`SFI_TX_TBN + 1))

// Idle delay counter, wide enough for 2**(7+3)
`define SFI_IDLE_CNT_W 11

`endif
